/* hdl/lsu_macros.svh */
`ifndef LSU_MACROS_SVH
`define LSU_MACROS_SVH

// Datapath geometry
`define LSU_DATA_W 32
`define LSU_LANES  4

// Load opcodes
`define OP_LB  6'b100000
`define OP_LH  6'b100001
`define OP_LWL 6'b100010
`define OP_LW  6'b100011
`define OP_LBU 6'b100100
`define OP_LHU 6'b100101
`define OP_LWR 6'b100110

// Store opcodes
`define OP_SB  6'b101000
`define OP_SH  6'b101001
`define OP_SW  6'b101011

`endif

/* hdl/mips_isa_pkg.sv */
package mips_isa_pkg;

    typedef logic [5:0] mips_op_t;
    typedef logic [4:0] mips_reg_t;

    // Register format, funct decodes the ALU op
    typedef struct packed {
        mips_op_t   op;
        mips_reg_t  rs;
        mips_reg_t  rt;
        mips_reg_t  rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } mips_r_fmt_t;

    // Immediate format, loads and stores use rs + imm
    typedef struct packed {
        mips_op_t    op;
        mips_reg_t   rs;
        mips_reg_t   rt;
        logic [15:0] imm;
    } mips_i_fmt_t;

    // Same 32-bit word seen through either format
    typedef union packed {
        mips_r_fmt_t r;
        mips_i_fmt_t i;
    } mips_instr_u;

endpackage

/* hdl/lsu_pkg.sv */
`include "lsu_macros.svh"

package lsu_pkg;

    import mips_isa_pkg::*;

    typedef enum logic [3:0] {
        ACC_NONE,
        ACC_LB,
        ACC_LBU,
        ACC_LH,
        ACC_LHU,
        ACC_LW,
        ACC_LWL,
        ACC_LWR,
        ACC_SB,
        ACC_SH,
        ACC_SW
    } acc_kind_e;

    typedef struct packed {
        acc_kind_e               kind;
        logic [`LSU_DATA_W-1:0]  addr; // Effective byte address
        mips_reg_t               dest;
        logic [`LSU_DATA_W-1:0]  data; // Store data or old rt value
    } acc_t;

    typedef struct packed {
        logic [`LSU_DATA_W-1:0] addr;
        logic [`LSU_LANES-1:0]  byteenable;
        logic                   read;
        logic                   write;
        logic [`LSU_DATA_W-1:0] writedata;
    } mem_req_t;

    typedef struct packed {
        logic                   valid;
        mips_reg_t              dest;
        logic [`LSU_DATA_W-1:0] data;
    } wb_t;

    function automatic logic is_load(acc_kind_e kind);
        return kind inside {ACC_LB, ACC_LBU, ACC_LH, ACC_LHU, ACC_LW, ACC_LWL, ACC_LWR};
    endfunction

    function automatic logic is_store(acc_kind_e kind);
        return kind inside {ACC_SB, ACC_SH, ACC_SW};
    endfunction

endpackage

/* hdl/mem_access_decode.sv */
`timescale 1ns/1ps
`include "lsu_macros.svh"

module mem_access_decode
    import mips_isa_pkg::*, lsu_pkg::*;
(
    input  logic                   issue,
    input  mips_instr_u            instr,
    input  logic [`LSU_DATA_W-1:0] base,
    input  logic [`LSU_DATA_W-1:0] rt_value,
    output acc_t                   acc
);

    mips_op_t               op;
    logic [`LSU_DATA_W-1:0] imm_sext;
    acc_kind_e              kind;

    assign op       = instr.r.op;
    assign imm_sext = {{(`LSU_DATA_W - 16){instr.i.imm[15]}}, instr.i.imm};

    always_comb begin
        kind = ACC_NONE;
        if (issue) begin
            case (op)
                `OP_LB:  kind = ACC_LB;
                `OP_LBU: kind = ACC_LBU;
                `OP_LH:  kind = ACC_LH;
                `OP_LHU: kind = ACC_LHU;
                `OP_LW:  kind = ACC_LW;
                `OP_LWL: kind = ACC_LWL;
                `OP_LWR: kind = ACC_LWR;
                `OP_SB:  kind = ACC_SB;
                `OP_SH:  kind = ACC_SH;
                `OP_SW:  kind = ACC_SW;
                default: kind = ACC_NONE; // Not a memory op here
            endcase
        end
    end

    always_comb begin
        acc.kind = kind;
        acc.addr = base + imm_sext;
        acc.dest = instr.i.rt;
        acc.data = rt_value; // Store data, or merge source for LWL/LWR
    end

endmodule

/* hdl/byte_enable_gen.sv */
`timescale 1ns/1ps
`include "lsu_macros.svh"

module byte_enable_gen
    import lsu_pkg::*;
(
    input  acc_kind_e              kind,
    input  logic [`LSU_DATA_W-1:0] addr,
    output logic [`LSU_DATA_W-1:0] word_addr,
    output logic [`LSU_LANES-1:0]  byteenable,
    output logic [1:0]             offset,
    output logic                   misaligned
);

    assign offset    = addr[1:0];
    assign word_addr = {addr[`LSU_DATA_W-1:2], 2'b00};

    always_comb begin
        byteenable = '0;
        misaligned = 1'b0;
        case (kind)
            ACC_LB, ACC_LBU, ACC_SB: begin
                byteenable = 4'b0001 << offset;
            end
            ACC_LH, ACC_LHU, ACC_SH: begin
                if (offset[0]) begin
                    misaligned = 1'b1; // Odd halfword address
                end else begin
                    byteenable = 4'b0011 << offset;
                end
            end
            ACC_LW, ACC_SW: begin
                if (offset != 2'd0) begin
                    misaligned = 1'b1;
                end else begin
                    byteenable = 4'b1111;
                end
            end
            ACC_LWL: begin
                byteenable = 4'b1111 << offset; // Lanes offset..3
            end
            ACC_LWR: begin
                byteenable = 4'b1111 >> (2'd3 - offset); // Lanes 0..offset
            end
            default: begin
                byteenable = '0;
            end
        endcase
    end

endmodule

/* hdl/store_align.sv */
`timescale 1ns/1ps
`include "lsu_macros.svh"

module store_align
    import lsu_pkg::*;
(
    input  acc_kind_e              kind,
    input  logic [1:0]             offset,
    input  logic [`LSU_DATA_W-1:0] data,
    output logic [`LSU_DATA_W-1:0] writedata
);

    logic [4:0] shamt;

    assign shamt = {offset, 3'b000}; // Byte offset in bits

    always_comb begin
        case (kind)
            ACC_SB: begin
                writedata = {24'd0, data[7:0]} << shamt;
            end
            ACC_SH: begin
                // Halfword lands in lanes 1:0 or 3:2
                writedata = {16'd0, data[15:0]} << {offset[1], 4'b0000};
            end
            ACC_SW: begin
                writedata = data;
            end
            default: begin
                writedata = '0;
            end
        endcase
    end

endmodule

/* hdl/load_track.sv */
`timescale 1ns/1ps
`include "lsu_macros.svh"

module load_track
    import lsu_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  acc_t       acc,
    input  logic [1:0] offset,
    input  logic       misaligned,
    output logic       pend_valid,
    output acc_t       pend,
    output logic [1:0] pend_offset
);

    logic load_issued;

    assign load_issued = is_load(acc.kind) && !misaligned;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pend_valid <= 1'b0;
        end else begin
            pend_valid <= load_issued; // High for exactly the return cycle
        end
    end

    // Payload follows the request every cycle
    always_ff @(posedge clk) begin
        pend        <= acc;
        pend_offset <= offset;
    end

endmodule

/* hdl/load_merge.sv */
`timescale 1ns/1ps
`include "lsu_macros.svh"

module load_merge
    import lsu_pkg::*;
(
    input  logic                   pend_valid,
    input  acc_t                   pend,
    input  logic [1:0]             pend_offset,
    input  logic [`LSU_DATA_W-1:0] readdata,
    output wb_t                    wb
);

    logic [7:0]             byte_sel;
    logic [15:0]            half_sel;
    logic [`LSU_LANES-1:0]  lane_take;
    logic [`LSU_DATA_W-1:0] merged;

    assign byte_sel = readdata[{pend_offset, 3'b000} +: 8];
    assign half_sel = pend_offset[1] ? readdata[31:16] : readdata[15:0];

    // Lanes taken from memory for the unaligned word loads
    always_comb begin
        case (pend.kind)
            ACC_LWL: lane_take = 4'b1111 << pend_offset;
            ACC_LWR: lane_take = 4'b1111 >> (2'd3 - pend_offset);
            default: lane_take = '0;
        endcase
    end

    always_comb begin
        merged = pend.data; // Old rt value
        for (int k = 0; k < `LSU_LANES; k++) begin
            if (lane_take[k]) begin
                merged[8*k +: 8] = readdata[8*k +: 8];
            end
        end
    end

    always_comb begin
        wb.valid = pend_valid;
        wb.dest  = pend.dest;
        case (pend.kind)
            ACC_LB: begin
                wb.data = {{24{byte_sel[7]}}, byte_sel};
            end
            ACC_LBU: begin
                wb.data = {24'd0, byte_sel};
            end
            ACC_LH: begin
                wb.data = {{16{half_sel[15]}}, half_sel};
            end
            ACC_LHU: begin
                wb.data = {16'd0, half_sel};
            end
            ACC_LW: begin
                wb.data = readdata;
            end
            ACC_LWL, ACC_LWR: begin
                wb.data = merged;
            end
            default: begin
                wb.data = '0;
            end
        endcase
    end

endmodule

/* hdl/lsu_top.sv */
`timescale 1ns/1ps
`include "lsu_macros.svh"

module lsu_top
    import mips_isa_pkg::*, lsu_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   issue,
    input  mips_instr_u            instr,
    input  logic [`LSU_DATA_W-1:0] base,
    input  logic [`LSU_DATA_W-1:0] rt_value,
    input  logic [`LSU_DATA_W-1:0] readdata,
    output mem_req_t               mem_req,
    output wb_t                    wb,
    output logic                   addr_error
);

    acc_t                   acc;
    logic [`LSU_DATA_W-1:0] word_addr;
    logic [`LSU_LANES-1:0]  byteenable;
    logic [1:0]             offset;
    logic                   misaligned;
    logic [`LSU_DATA_W-1:0] writedata;
    logic                   pend_valid;
    acc_t                   pend;
    logic [1:0]             pend_offset;

    mem_access_decode u_decode (
        .issue    (issue),
        .instr    (instr),
        .base     (base),
        .rt_value (rt_value),
        .acc      (acc)
    );

    byte_enable_gen u_be (
        .kind       (acc.kind),
        .addr       (acc.addr),
        .word_addr  (word_addr),
        .byteenable (byteenable),
        .offset     (offset),
        .misaligned (misaligned)
    );

    store_align u_store (
        .kind      (acc.kind),
        .offset    (offset),
        .data      (acc.data),
        .writedata (writedata)
    );

    load_track u_track (
        .clk         (clk),
        .rst_n       (rst_n),
        .acc         (acc),
        .offset      (offset),
        .misaligned  (misaligned),
        .pend_valid  (pend_valid),
        .pend        (pend),
        .pend_offset (pend_offset)
    );

    load_merge u_merge (
        .pend_valid  (pend_valid),
        .pend        (pend),
        .pend_offset (pend_offset),
        .readdata    (readdata),
        .wb          (wb)
    );

    always_comb begin
        mem_req.addr       = word_addr;
        mem_req.byteenable = byteenable;
        mem_req.read       = is_load(acc.kind) && !misaligned;
        mem_req.write      = is_store(acc.kind) && !misaligned; // No strobe on bad address
        mem_req.writedata  = writedata;
    end

    assign addr_error = misaligned;

endmodule

/* testbench/tb_lsu_mem.sv */
`timescale 1ns/1ps
`include "lsu_macros.svh"

module tb_lsu_mem
    import lsu_pkg::*;
(
    input  logic                   clk,
    input  mem_req_t               req,
    output logic [`LSU_DATA_W-1:0] readdata
);

    localparam logic [31:0] SEED = 32'h2e7b_d934;

    logic [`LSU_DATA_W-1:0] words [0:255];
    logic [7:0]             idx;
    logic [31:0]            state;

    assign idx = req.addr[9:2]; // 256 words, wraps above 1 KiB

    function automatic logic [31:0] lcg_next(logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    initial begin
        state    = SEED;
        readdata = '0;
        for (int i = 0; i < 256; i++) begin
            state    = lcg_next(state);
            words[i] = state;
        end
    end

    // Byte-enabled write, read data returned one cycle later
    always @(posedge clk) begin
        if (req.write) begin
            for (int k = 0; k < `LSU_LANES; k++) begin
                if (req.byteenable[k]) begin
                    words[idx][8*k +: 8] <= req.writedata[8*k +: 8];
                end
            end
        end
        if (req.read) begin
            readdata <= words[idx];
        end
    end

endmodule

/* testbench/tb_lsu.sv */
`timescale 1ns/1ps
`include "lsu_macros.svh"

module tb_lsu
    import mips_isa_pkg::*, lsu_pkg::*;
;

    typedef struct packed {
        logic [5:0]  op;
        logic [4:0]  rt;
        logic [31:0] base;
        logic [15:0] imm;
        logic [31:0] rt_value;
        logic        use_reg; // Take old value from the shadow register file
        logic [3:0]  be;
        logic        err;
    } row_t;

    localparam int NROWS = 21;
    localparam row_t ROWS [NROWS] = '{
        '{`OP_SB,  5'd3,  32'h100, 16'h0001, 32'h0000_00a5, 1'b0, 4'b0010, 1'b0},
        '{`OP_SH,  5'd3,  32'h100, 16'h0002, 32'hbeef_1234, 1'b0, 4'b1100, 1'b0},
        '{`OP_LW,  5'd2,  32'h100, 16'h0000, 32'h0,         1'b0, 4'b1111, 1'b0},
        '{`OP_SW,  5'd4,  32'h104, 16'h0000, 32'hcafe_f00d, 1'b0, 4'b1111, 1'b0},
        '{`OP_LW,  5'd5,  32'h0fc, 16'h0008, 32'h0,         1'b0, 4'b1111, 1'b0},
        '{`OP_LB,  5'd6,  32'h104, 16'h0003, 32'h0,         1'b0, 4'b1000, 1'b0},
        '{`OP_LBU, 5'd7,  32'h104, 16'h0003, 32'h0,         1'b0, 4'b1000, 1'b0},
        '{`OP_LH,  5'd8,  32'h104, 16'h0002, 32'h0,         1'b0, 4'b1100, 1'b0},
        '{`OP_LHU, 5'd9,  32'h104, 16'h0002, 32'h0,         1'b0, 4'b1100, 1'b0},
        '{`OP_LB,  5'd6,  32'h110, 16'hfffd, 32'h0,         1'b0, 4'b0010, 1'b0},
        '{`OP_LWL, 5'd10, 32'h120, 16'h0001, 32'h1122_3344, 1'b0, 4'b1110, 1'b0},
        '{`OP_LWR, 5'd10, 32'h120, 16'h0004, 32'h0,         1'b1, 4'b0001, 1'b0},
        '{`OP_LWL, 5'd11, 32'h130, 16'h0002, 32'h5566_7788, 1'b0, 4'b1100, 1'b0},
        '{`OP_LWR, 5'd11, 32'h130, 16'h0005, 32'h0,         1'b1, 4'b0011, 1'b0},
        '{`OP_LH,  5'd12, 32'h100, 16'h0001, 32'h0,         1'b0, 4'b0000, 1'b1},
        '{`OP_SH,  5'd12, 32'h100, 16'h0003, 32'h0000_7777, 1'b0, 4'b0000, 1'b1},
        '{`OP_LW,  5'd13, 32'h100, 16'h0002, 32'h0,         1'b0, 4'b0000, 1'b1},
        '{`OP_SW,  5'd13, 32'h100, 16'h0001, 32'h1234_5678, 1'b0, 4'b0000, 1'b1},
        '{`OP_LW,  5'd20, 32'h140, 16'h0000, 32'h0,         1'b0, 4'b1111, 1'b0},
        '{`OP_LW,  5'd21, 32'h144, 16'h0000, 32'h0,         1'b0, 4'b1111, 1'b0},
        '{`OP_LBU, 5'd22, 32'h148, 16'h0002, 32'h0,         1'b0, 4'b0100, 1'b0}
    };

    localparam logic [5:0] SWEEP_OPS [10] = '{`OP_LB, `OP_LBU, `OP_LH, `OP_LHU, `OP_LW,
                                              `OP_LWL, `OP_LWR, `OP_SB, `OP_SH, `OP_SW};

    logic        clk;
    logic        rst_n;
    logic        issue;
    mips_instr_u instr;
    logic [31:0] base;
    logic [31:0] rt_value;
    logic [31:0] readdata;
    mem_req_t    mem_req;
    wb_t         wb;
    logic        addr_error;

    logic [31:0] shadow [0:255];
    logic [31:0] regs [0:31];
    wb_t         exp_q [$];
    logic [31:0] rnd;
    int          req_errs;
    int          wb_errs;
    int          flag_errs;
    int          other_errs;

    lsu_top dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .issue      (issue),
        .instr      (instr),
        .base       (base),
        .rt_value   (rt_value),
        .readdata   (readdata),
        .mem_req    (mem_req),
        .wb         (wb),
        .addr_error (addr_error)
    );

    tb_lsu_mem u_mem (
        .clk      (clk),
        .req      (mem_req),
        .readdata (readdata)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next(logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic op_is_load(logic [5:0] op);
        return op inside {`OP_LB, `OP_LBU, `OP_LH, `OP_LHU, `OP_LW, `OP_LWL, `OP_LWR};
    endfunction

    function automatic logic op_is_store(logic [5:0] op);
        return op inside {`OP_SB, `OP_SH, `OP_SW};
    endfunction

    function automatic logic expect_err(logic [5:0] op, logic [1:0] off);
        if (op inside {`OP_LH, `OP_LHU, `OP_SH}) return off[0];
        if (op inside {`OP_LW, `OP_SW}) return off != 2'd0;
        return 1'b0;
    endfunction

    function automatic logic [3:0] expect_be(logic [5:0] op, logic [1:0] off);
        logic [3:0] be;
        be = '0;
        for (int k = 0; k < 4; k++) begin
            case (op)
                `OP_LB, `OP_LBU, `OP_SB: be[k] = (k == int'(off));
                `OP_LH, `OP_LHU, `OP_SH: be[k] = !off[0] && (k / 2 == int'(off[1]));
                `OP_LW, `OP_SW:          be[k] = (off == 2'd0);
                `OP_LWL:                 be[k] = (k >= int'(off));
                `OP_LWR:                 be[k] = (k <= int'(off));
                default:                 be[k] = 1'b0;
            endcase
        end
        return be;
    endfunction

    function automatic mem_req_t expect_req(logic [5:0] op, logic [31:0] addr,
                                            logic [31:0] rv, logic [3:0] be, logic err);
        mem_req_t r;
        r.addr       = {addr[31:2], 2'b00};
        r.byteenable = be;
        r.read       = op_is_load(op) && !err;
        r.write      = op_is_store(op) && !err;
        case (op)
            `OP_SB:  r.writedata = {24'd0, rv[7:0]} << (8 * addr[1:0]);
            `OP_SH:  r.writedata = {16'd0, rv[15:0]} << (16 * addr[1]);
            `OP_SW:  r.writedata = rv;
            default: r.writedata = '0;
        endcase
        return r;
    endfunction

    function automatic logic [31:0] load_value(logic [5:0] op, logic [31:0] w,
                                               logic [1:0] off, logic [31:0] old);
        logic [7:0]  b;
        logic [15:0] h;
        logic [31:0] v;
        b = w[8*off +: 8];
        h = w[16*off[1] +: 16];
        v = old;
        case (op)
            `OP_LB:  v = {{24{b[7]}}, b};
            `OP_LBU: v = {24'd0, b};
            `OP_LH:  v = {{16{h[15]}}, h};
            `OP_LHU: v = {16'd0, h};
            `OP_LW:  v = w;
            default: begin
                for (int k = 0; k < 4; k++) begin
                    if ((op == `OP_LWL && k >= int'(off)) || (op == `OP_LWR && k <= int'(off)))
                        v[8*k +: 8] = w[8*k +: 8];
                end
            end
        endcase
        return v;
    endfunction

    task automatic check_req(mem_req_t exp);
        if (mem_req !== exp) begin
            req_errs++;
            $display("[ERROR] %0t mem_req exp=%h got=%h", $time, exp, mem_req);
        end
    endtask

    task automatic check_wb(wb_t exp);
        if (wb !== exp) begin
            wb_errs++;
            $display("[ERROR] %0t wb exp=%h got=%h", $time, exp, wb);
        end
    endtask

    task automatic check_err(logic exp);
        if (addr_error !== exp) begin
            flag_errs++;
            $display("[ERROR] %0t addr_error exp=%b got=%b", $time, exp, addr_error);
        end
    endtask

    // Issues one access, checks the request and updates the shadow state
    task automatic issue_access(logic [5:0] op, logic [4:0] rt, logic [31:0] b,
                                logic [15:0] imm, logic [31:0] rv, logic [3:0] be, logic err);
        logic [31:0] addr;
        logic [7:0]  idx;
        mem_req_t    r;
        wb_t         w;
        addr = b + {{16{imm[15]}}, imm};
        idx  = addr[9:2];
        r    = expect_req(op, addr, rv, be, err);
        @(negedge clk);
        issue        = 1'b1;
        instr.i.op   = op;
        instr.i.rs   = 5'd1;
        instr.i.rt   = rt;
        instr.i.imm  = imm;
        base         = b;
        rt_value     = rv;
        #1;
        check_req(r);
        check_err(err);
        if (op_is_store(op) && !err) begin
            for (int k = 0; k < 4; k++) begin
                if (be[k]) shadow[idx][8*k +: 8] = r.writedata[8*k +: 8];
            end
        end
        if (op_is_load(op) && !err) begin
            w.valid  = 1'b1;
            w.dest   = rt;
            w.data   = load_value(op, shadow[idx], addr[1:0], rv);
            regs[rt] = w.data;
            exp_q.push_back(w);
        end
    endtask

    // Write-back monitor, samples mid-cycle
    initial begin
        forever begin
            @(negedge clk);
            if (wb.valid) begin
                if (exp_q.size() == 0) begin
                    other_errs++;
                    $display("%0t: write-back seen with no load outstanding", $time);
                end else begin
                    check_wb(exp_q.pop_front());
                end
            end else if (exp_q.size() != 0) begin
                // Any queued load was issued in the previous cycle
                other_errs++;
                $display("%0t: no write-back in the cycle after a load", $time);
                exp_q.delete(0);
            end
        end
    end

    initial begin
        logic [31:0] rv;
        int          t;
        issue      = 1'b0;
        instr      = '0;
        base       = '0;
        rt_value   = '0;
        rst_n      = 1'b0;
        rnd        = 32'h2e7b_d934;
        req_errs   = 0;
        wb_errs    = 0;
        flag_errs  = 0;
        other_errs = 0;
        for (int i = 0; i < 32; i++) regs[i] = '0;
        repeat (5) @(posedge clk);
        for (int i = 0; i < 256; i++) shadow[i] = u_mem.words[i];
        @(negedge clk);
        rst_n = 1'b1;
        for (int i = 0; i < NROWS; i++) begin
            rv = ROWS[i].use_reg ? regs[ROWS[i].rt] : ROWS[i].rt_value;
            issue_access(ROWS[i].op, ROWS[i].rt, ROWS[i].base, ROWS[i].imm, rv,
                         ROWS[i].be, ROWS[i].err);
        end
        for (int i = 0; i < 10; i++) begin
            for (int off = 0; off < 4; off++) begin
                rnd = lcg_next(rnd);
                issue_access(SWEEP_OPS[i], 5'(i + 11), 32'h200 + 32'(i * 16), 16'(off), rnd,
                             expect_be(SWEEP_OPS[i], 2'(off)),
                             expect_err(SWEEP_OPS[i], 2'(off)));
            end
        end
        @(negedge clk);
        issue = 1'b0;
        #1;
        check_req(expect_req(6'd0, base + {{16{instr.i.imm[15]}}, instr.i.imm},
                             32'd0, 4'd0, 1'b0));
        check_err(1'b0);
        t = 0;
        while (exp_q.size() != 0 && t < 20) begin
            @(negedge clk);
            t++;
        end
        if (exp_q.size() != 0) begin
            other_errs++;
            $display("Timed out waiting for %0d write-backs", exp_q.size());
        end
        repeat (3) @(negedge clk);
        $display("errors: req=%0d wb=%0d addr_error=%0d other=%0d",
                 req_errs, wb_errs, flag_errs, other_errs);
        if (req_errs + wb_errs + flag_errs + other_errs == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

/* project.f */
+incdir+hdl
hdl/mips_isa_pkg.sv
hdl/lsu_pkg.sv
hdl/mem_access_decode.sv
hdl/byte_enable_gen.sv
hdl/store_align.sv
hdl/load_track.sv
hdl/load_merge.sv
hdl/lsu_top.sv
testbench/tb_lsu_mem.sv
testbench/tb_lsu.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the LSU testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f project.f --top-module tb_lsu -Mdir obj_dir -o tb_lsu_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/tb_lsu_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "=== PASS ==="; then
    exit 0
fi
echo "Pass message not found"
exit 1
